// File: design/ahb_pkg.sv
package ahb_pkg;

    // ==============================
    // bus structures
    // ==============================

    typedef struct packed {
        logic [31:0] haddr;
        logic [1:0]  htrans;
        logic [2:0]  hsize;
        logic [3:0]  hprot;                         // carried along, no slave checks it.
        logic        hwrite;
        logic        hready;                        // bus-wide ready from the response mux.
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hreadyout;
        logic        hresp;
    } ahb_rsp_t;

    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_busy   = 2'b01;
    localparam logic [1:0] htrans_nonseq = 2'b10;
    localparam logic [1:0] htrans_seq    = 2'b11;

    localparam logic hresp_okay  = 1'b0;
    localparam logic hresp_error = 1'b1;

    // ==============================
    // address map
    // ==============================

    localparam logic [31:0] ram_base = 32'h0000_0000;
    localparam logic [31:0] ram_mask = 32'hFFFF_0000;  // 64 KiB window.
    localparam logic [31:0] tmr_base = 32'h4000_0000;
    localparam logic [31:0] tmr_mask = 32'hFFFF_F000;  // 4 KiB window.

    localparam logic [3:0] tmr_ctrl   = 4'h0;          // bit 0 enable, bit 1 irq enable.
    localparam logic [3:0] tmr_load   = 4'h4;
    localparam logic [3:0] tmr_value  = 4'h8;
    localparam logic [3:0] tmr_status = 4'hC;          // bit 0 expired, write 1 to clear.

    // only nonseq and seq carry a real transfer.
    function automatic logic trans_valid(input logic [1:0] htrans);
        case (htrans)
            htrans_nonseq, htrans_seq: trans_valid = 1'b1;
            htrans_idle, htrans_busy:  trans_valid = 1'b0;
            default:                   trans_valid = 1'b0;
        endcase
    endfunction

endpackage

// File: design/block_ram.sv
`timescale 1ns/1ps

module block_ram #(
    parameter int addr_width = 14
) (
    input  logic                  HCLK,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [31:0]           wr_data,
    input  logic [3:0]            wr_be,
    input  logic [addr_width-1:0] rd_addr,
    output logic [31:0]           rd_data
);

    localparam int depth = 2 ** addr_width;

    logic [31:0] mem [depth];

    // ==============================
    // write port
    // ==============================

    always_ff @(posedge HCLK)
    begin
        for (int lane = 0; lane < 4; lane++)
        begin
            if (wr_be[lane])
            begin
                mem[wr_addr][lane*8 +: 8] <= wr_data[lane*8 +: 8];  // one byte per enable.
            end
        end
    end

    // ==============================
    // read port
    // ==============================

    // the read sees the old word when both ports hit the same address.
    always_ff @(posedge HCLK)
    begin
        rd_data <= mem[rd_addr];                    // data one cycle after the address.
    end

endmodule

// File: design/ahb_bram_slave.sv
`timescale 1ns/1ps

module ahb_bram_slave
    import ahb_pkg::*;
#(
    parameter int addr_width = 14
) (
    input  logic     HCLK,
    input  logic     HRESETn,
    input  logic     hsel,
    input  ahb_req_t req,
    input  logic [31:0] hwdata,
    output ahb_rsp_t rsp
);

    logic                  accept;
    logic [3:0]            lane_dec;
    logic [addr_width-1:0] word_addr;
    logic [3:0]            lanes_q;
    logic [addr_width-1:0] addr_q;
    logic                  wr_pending;
    logic [3:0]            ram_we;
    logic [31:0]           ram_rdata;
    logic                  fwd_hit;
    logic [3:0]            fwd_lanes;
    logic [31:0]           fwd_data;

    assign accept    = hsel && req.hready && trans_valid(req.htrans);
    assign word_addr = req.haddr[addr_width+1:2];

    // ==============================
    // byte lane decode
    // ==============================

    always_comb
    begin
        case ({req.haddr[1:0], req.hsize[1:0]})
            4'h0:    lane_dec = 4'h1;               // byte 0.
            4'h1:    lane_dec = 4'h3;               // low halfword.
            4'h2:    lane_dec = 4'hF;               // full word.
            4'h4:    lane_dec = 4'h2;
            4'h8:    lane_dec = 4'h4;
            4'h9:    lane_dec = 4'hC;               // high halfword.
            4'hC:    lane_dec = 4'h8;
            default: lane_dec = 4'h0;               // unaligned accesses write nothing.
        endcase
        if (req.hsize[2])
        begin
            lane_dec = 4'h0;                        // wider than the bus.
        end
    end

    // ==============================
    // write data phase
    // ==============================

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            lanes_q    <= '0;
            addr_q     <= '0;
            wr_pending <= 1'b0;
        end
        else
        begin
            if (accept && req.hwrite)
            begin
                lanes_q <= lane_dec;
            end
            if (accept)
            begin
                addr_q <= word_addr;
            end
            wr_pending <= accept && req.hwrite;     // low again when hready drops.
        end
    end

    assign ram_we = wr_pending ? lanes_q : 4'h0;

    // a read right behind a write to the same word gets the new bytes here.
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            fwd_hit   <= 1'b0;
            fwd_lanes <= '0;
        end
        else
        begin
            fwd_hit   <= accept && !req.hwrite && wr_pending && (word_addr == addr_q);
            fwd_lanes <= lanes_q;
        end
    end

    always_ff @(posedge HCLK)
    begin
        fwd_data <= hwdata;                         // the word the RAM is taking now.
    end

    block_ram #(
        .addr_width(addr_width)
    ) ram_i (
        .HCLK   (HCLK),
        .wr_addr(addr_q),
        .wr_data(hwdata),
        .wr_be  (ram_we),
        .rd_addr(word_addr),
        .rd_data(ram_rdata)
    );

    always_comb
    begin
        for (int lane = 0; lane < 4; lane++)
        begin
            rsp.hrdata[lane*8 +: 8] = (fwd_hit && fwd_lanes[lane]) ?
                                      fwd_data[lane*8 +: 8] : ram_rdata[lane*8 +: 8];
        end
        rsp.hreadyout = 1'b1;                       // zero wait states.
        rsp.hresp     = hresp_okay;
    end

    // the RAM only writes while the whole bus is ready.
    write_only_when_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (ram_we != 4'h0) |-> req.hready)
        else $error("ram write enables active while hready is low");

endmodule

// File: design/ahb_timer_slave.sv
`timescale 1ns/1ps

module ahb_timer_slave
    import ahb_pkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        hsel,
    input  ahb_req_t    req,
    input  logic [31:0] hwdata,
    output ahb_rsp_t    rsp,
    output logic        irq
);

    logic        accept;
    logic        wr_pending;
    logic [3:0]  off_q;
    logic        wr_ctrl;
    logic        wr_load;
    logic        wr_status;
    logic [1:0]  ctrl_q;
    logic [31:0] load_q;
    logic [31:0] count_q;
    logic        expired_q;
    logic        irq_q;
    logic        at_zero;

    assign accept = hsel && req.hready && trans_valid(req.htrans);

    // ==============================
    // address phase capture
    // ==============================

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            wr_pending <= 1'b0;
            off_q      <= '0;
        end
        else
        begin
            wr_pending <= accept && req.hwrite;
            if (accept)
            begin
                off_q <= req.haddr[3:0];            // byte offset inside the block.
            end
        end
    end

    assign wr_ctrl   = wr_pending && (off_q == tmr_ctrl);
    assign wr_load   = wr_pending && (off_q == tmr_load);
    assign wr_status = wr_pending && (off_q == tmr_status);
    assign at_zero   = ctrl_q[0] && (count_q == 32'd0);

    // ==============================
    // registers and counter
    // ==============================

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            ctrl_q    <= '0;
            load_q    <= '0;
            count_q   <= '0;
            expired_q <= 1'b0;
            irq_q     <= 1'b0;
        end
        else
        begin
            if (wr_ctrl)
            begin
                ctrl_q <= hwdata[1:0];
            end
            if (wr_load)
            begin
                load_q <= hwdata;
            end

            if (wr_load)
            begin
                count_q <= hwdata;                  // a new load restarts the count.
            end
            else if (at_zero)
            begin
                count_q <= load_q;
            end
            else if (ctrl_q[0])
            begin
                count_q <= count_q - 32'd1;
            end

            // setting wins over a clear on the same edge.
            if (at_zero)
            begin
                expired_q <= 1'b1;
            end
            else if (wr_status && hwdata[0])
            begin
                expired_q <= 1'b0;
            end

            irq_q <= expired_q && ctrl_q[1];
        end
    end

    assign irq = irq_q;

    always_comb
    begin
        case (off_q)
            tmr_ctrl:   rsp.hrdata = {30'd0, ctrl_q};
            tmr_load:   rsp.hrdata = load_q;
            tmr_value:  rsp.hrdata = count_q;
            tmr_status: rsp.hrdata = {31'd0, expired_q};
            default:    rsp.hrdata = 32'd0;
        endcase
        rsp.hreadyout = 1'b1;
        rsp.hresp     = hresp_okay;
    end

    // an expiry always comes together with the reload of the count.
    expired_after_zero: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $rose(expired_q) |-> ($past(count_q == 32'd0) && count_q == load_q))
        else $error("timer expired without the count reaching zero and reloading");

endmodule

// File: design/ahb_decoder_mux.sv
`timescale 1ns/1ps

module ahb_decoder_mux
    import ahb_pkg::*;
(
    input  logic     HCLK,
    input  logic     HRESETn,
    input  ahb_req_t bus_req,
    input  ahb_rsp_t ram_rsp,
    input  ahb_rsp_t tmr_rsp,
    output logic     hsel_ram,
    output logic     hsel_tmr,
    output ahb_req_t slv_req,
    output ahb_rsp_t bus_rsp
);

    typedef enum logic [1:0] {sel_none, sel_ram, sel_tmr, sel_def} sel_e;
    typedef enum logic {def_idle, def_wait} def_e;

    logic     hsel_def;
    logic     accept;
    sel_e     sel_q;
    def_e     def_q;
    ahb_rsp_t def_rsp;

    // ==============================
    // address phase decode
    // ==============================

    assign hsel_ram = (bus_req.haddr & ram_mask) == ram_base;
    assign hsel_tmr = (bus_req.haddr & tmr_mask) == tmr_base;
    assign hsel_def = !hsel_ram && !hsel_tmr;   // everything outside the map.
    assign accept   = trans_valid(bus_req.htrans) && bus_rsp.hreadyout;

    always_comb
    begin
        slv_req        = bus_req;
        slv_req.hready = bus_rsp.hreadyout;     // the manager's own hready is not used.
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sel_q <= sel_none;
        end
        else if (bus_rsp.hreadyout)
        begin
            if (!accept)
            begin
                sel_q <= sel_none;
            end
            else if (hsel_ram)
            begin
                sel_q <= sel_ram;
            end
            else if (hsel_tmr)
            begin
                sel_q <= sel_tmr;
            end
            else
            begin
                sel_q <= sel_def;
            end
        end
    end

    // ==============================
    // default slave
    // ==============================

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            def_q <= def_idle;
        end
        else
        begin
            case (def_q)
                def_idle: if (accept && hsel_def) def_q <= def_wait;
                def_wait: def_q <= def_idle;    // second cycle of the response.
                default:  def_q <= def_idle;
            endcase
        end
    end

    assign def_rsp.hrdata    = 32'd0;
    assign def_rsp.hreadyout = (def_q == def_idle);
    assign def_rsp.hresp     = hresp_error;

    always_comb
    begin
        case (sel_q)
            sel_ram: bus_rsp = ram_rsp;
            sel_tmr: bus_rsp = tmr_rsp;
            sel_def: bus_rsp = def_rsp;
            default: bus_rsp = '{hrdata: 32'd0, hreadyout: 1'b1, hresp: hresp_okay};
        endcase
    end

    // the stalled ERROR cycle is always followed by the completing one.
    error_two_cycles: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (bus_rsp.hresp == hresp_error && !bus_rsp.hreadyout) |=>
            (bus_rsp.hresp == hresp_error && bus_rsp.hreadyout))
        else $error("error response not completed in its second cycle");

endmodule

// File: design/ahb_subsystem_top.sv
`timescale 1ns/1ps

module ahb_subsystem_top
    import ahb_pkg::*;
#(
    parameter int addr_width = 14
) (
    input  logic        HCLK,
    input  logic        HRESETn,
    input  ahb_req_t    bus_req,
    input  logic [31:0] hwdata,
    output ahb_rsp_t    bus_rsp,
    output logic        irq
);

    logic     hsel_ram;
    logic     hsel_tmr;
    ahb_req_t slv_req;                           // request with the combined hready.
    ahb_rsp_t ram_rsp;
    ahb_rsp_t tmr_rsp;

    ahb_decoder_mux mux_i (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .bus_req (bus_req),
        .ram_rsp (ram_rsp),
        .tmr_rsp (tmr_rsp),
        .hsel_ram(hsel_ram),
        .hsel_tmr(hsel_tmr),
        .slv_req (slv_req),
        .bus_rsp (bus_rsp)
    );

    ahb_bram_slave #(
        .addr_width(addr_width)
    ) ram_slave_i (
        .HCLK   (HCLK),
        .HRESETn(HRESETn),
        .hsel   (hsel_ram),
        .req    (slv_req),
        .hwdata (hwdata),
        .rsp    (ram_rsp)
    );

    ahb_timer_slave tmr_slave_i (
        .HCLK   (HCLK),
        .HRESETn(HRESETn),
        .hsel   (hsel_tmr),
        .req    (slv_req),
        .hwdata (hwdata),
        .rsp    (tmr_rsp),
        .irq    (irq)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic HCLK,
    output logic HRESETn
);

    initial
    begin
        HCLK = 1'b0;
        forever #10 HCLK = ~HCLK;               // 20 ns period.
    end

    initial
    begin
        HRESETn = 1'b0;
        repeat (10) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;                         // released away from the rising edge.
    end

endmodule

// File: sim/tb_ahb_tasks.svh
`ifndef tb_ahb_tasks_svh
`define tb_ahb_tasks_svh

localparam int reset_limit = 50;
localparam int ready_limit = 16;
localparam int irq_limit   = 200;

// ==============================
// bounded waits
// ==============================

task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (HRESETn !== 1'b1 && cycles < reset_limit)
    begin
        @(negedge HCLK);
        cycles++;
    end
    if (HRESETn !== 1'b1)
    begin
        fail_count++;
        $display("timeout: reset never released after %0d cycles at %0t", cycles, $time);
        report_and_finish();
    end
endtask

task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!bus_rsp.hreadyout && cycles < ready_limit)
    begin
        @(negedge HCLK);
        cycles++;
    end
    if (!bus_rsp.hreadyout)
    begin
        fail_count++;
        $display("timeout: hreadyout stayed low for %0d cycles at %0t", cycles, $time);
        report_and_finish();
    end
endtask

task automatic wait_irq();
    int cycles;
    cycles = 0;
    while (!irq && cycles < irq_limit)
    begin
        @(negedge HCLK);
        cycles++;
    end
    if (!irq)
    begin
        fail_count++;
        $display("timeout: timer interrupt never rose within %0d cycles at %0t", cycles, $time);
        report_and_finish();
    end
endtask

// ==============================
// bus transfers
// ==============================

task automatic drive_addr(input logic write, input logic [31:0] addr, input logic [2:0] size);
    bus_req.haddr  = addr;
    bus_req.htrans = htrans_nonseq;
    bus_req.hsize  = size;
    bus_req.hwrite = write;
endtask

task automatic do_transfer(input logic write, input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] wdata, input logic [31:0] rdata_exp,
                           input logic want_err);
    drive_addr(write, addr, size);
    wait_ready();
    @(negedge HCLK);                            // address phase taken at the edge just passed.
    bus_req.htrans = htrans_idle;
    hwdata  = write ? wdata : 32'd0;
    exp_rd  = rdata_exp;
    chk_rd  = !write && !want_err;
    chk_ok  = !want_err;
    exp_err = want_err;
    wait_ready();                               // rides out the first ERROR cycle.
    @(negedge HCLK);
    chk_rd  = 1'b0;
    chk_ok  = 1'b0;
    exp_err = 1'b0;
endtask

task automatic ahb_write(input logic [31:0] addr, input logic [2:0] size,
                         input logic [31:0] data);
    do_transfer(1'b1, addr, size, data, 32'd0, 1'b0);
endtask

task automatic ahb_read(input logic [31:0] addr, input logic [2:0] size,
                        input logic [31:0] expected);
    do_transfer(1'b0, addr, size, 32'd0, expected, 1'b0);
endtask

// the read address phase overlaps the write data phase of the same word.
task automatic write_then_read(input logic [31:0] addr, input logic [31:0] data);
    drive_addr(1'b1, addr, 3'd2);
    wait_ready();
    @(negedge HCLK);
    drive_addr(1'b0, addr, 3'd2);
    hwdata = data;
    chk_ok = 1'b1;
    wait_ready();
    @(negedge HCLK);
    bus_req.htrans = htrans_idle;
    hwdata = 32'd0;
    exp_rd = data;                              // must come from the forwarding path.
    chk_rd = 1'b1;
    wait_ready();
    @(negedge HCLK);
    chk_rd = 1'b0;
    chk_ok = 1'b0;
endtask

`endif

// File: sim/ahb_subsystem_tb.sv
`timescale 1ns/1ps

module ahb_subsystem_tb
    import ahb_pkg::*;
();

    localparam int addr_width  = 14;
    localparam int word_writes = 32;

    logic        HCLK;
    logic        HRESETn;
    ahb_req_t    bus_req;
    logic [31:0] hwdata;
    ahb_rsp_t    bus_rsp;
    logic        irq;

    logic        chk_reset;
    logic        chk_ok;
    logic        chk_rd;
    logic [31:0] exp_rd;
    logic        exp_err;
    logic        chk_irq;
    logic        exp_irq;

    int          fail_count;
    int          fail_mark;
    int          tests_run;
    integer      seed;
    logic [31:0] ram_model [2**addr_width];
    logic [31:0] written [$];

    tb_clock_gen clk_gen_i (
        .HCLK   (HCLK),
        .HRESETn(HRESETn)
    );

    ahb_subsystem_top #(
        .addr_width(addr_width)
    ) dut_i (
        .HCLK   (HCLK),
        .HRESETn(HRESETn),
        .bus_req(bus_req),
        .hwdata (hwdata),
        .bus_rsp(bus_rsp),
        .irq    (irq)
    );

    // ==============================
    // bus and data checks
    // ==============================

    reset_state: assert property (@(posedge HCLK)
        chk_reset |-> (bus_rsp.hreadyout && bus_rsp.hresp == hresp_okay && !irq))
        else
        begin
            fail_count++;
            $display("FAIL %0t: bus not idle or irq high after reset", $time);
        end

    okay_one_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        chk_ok |-> (bus_rsp.hreadyout && bus_rsp.hresp == hresp_okay))
        else
        begin
            fail_count++;
            $display("FAIL %0t: OKAY transfer stalled or answered ERROR", $time);
        end

    read_data: assert property (@(posedge HCLK) disable iff (!HRESETn)
        chk_rd |-> (bus_rsp.hrdata == exp_rd))
        else
        begin
            fail_count++;
            $display("FAIL %0t: read %h, expected %h", $time, $sampled(bus_rsp.hrdata),
                     $sampled(exp_rd));
        end

    error_first: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $rose(exp_err) |-> (bus_rsp.hresp == hresp_error && !bus_rsp.hreadyout))
        else
        begin
            fail_count++;
            $display("FAIL %0t: first ERROR cycle missing", $time);
        end

    error_second: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $rose(exp_err) |=> (bus_rsp.hresp == hresp_error && bus_rsp.hreadyout))
        else
        begin
            fail_count++;
            $display("FAIL %0t: second ERROR cycle missing", $time);
        end

    no_stray_error: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (bus_rsp.hresp == hresp_error) |-> exp_err)
        else
        begin
            fail_count++;
            $display("FAIL %0t: ERROR response on a mapped transfer", $time);
        end

    irq_level: assert property (@(posedge HCLK) disable iff (!HRESETn)
        chk_irq |-> (irq == exp_irq))
        else
        begin
            fail_count++;
            $display("FAIL %0t: irq is %b, expected %b", $time, $sampled(irq), $sampled(exp_irq));
        end

    // ==============================
    // reporting and RAM model
    // ==============================

    task automatic end_test(input string name);
        tests_run++;
        $display("%s: %0d failures", name, fail_count - fail_mark);
        fail_mark = fail_count;
    endtask

    task automatic report_and_finish();
        $display("tests run %0d, failures %0d", tests_run, fail_count);
        if (fail_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    `include "tb_ahb_tasks.svh"

    // byte lanes per AHB size and low address bits; misaligned accesses get none.
    function automatic logic [3:0] lane_mask(input logic [1:0] offset, input logic [2:0] size);
        logic [3:0] mask;
        mask = 4'h0;
        if (size == 3'd0)
            mask = 4'h1 << offset;
        else if (size == 3'd1 && !offset[0])
            mask = offset[1] ? 4'hC : 4'h3;
        else if (size == 3'd2 && offset == 2'd0)
            mask = 4'hF;
        return mask;
    endfunction

    task automatic ram_write(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        logic [3:0]  mask;
        logic [31:0] word;
        mask = lane_mask(addr[1:0], size);
        word = ram_model[addr[15:2]];
        for (int lane = 0; lane < 4; lane++)
            if (mask[lane])
                word[lane*8 +: 8] = data[lane*8 +: 8];
        ram_model[addr[15:2]] = word;
        ahb_write(addr, size, data);
    endtask

    task automatic ram_check(input logic [31:0] addr);
        ahb_read({addr[31:2], 2'b00}, 3'd2, ram_model[addr[15:2]]);
    endtask

    initial
    begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] base;
        seed       = 32'h56b0f517;
        bus_req    = '0;
        bus_req.hready = 1'b1;                  // ignored by the DUT.
        hwdata     = 32'd0;
        chk_reset  = 1'b0;
        chk_ok     = 1'b0;
        chk_rd     = 1'b0;
        exp_rd     = 32'd0;
        exp_err    = 1'b0;
        chk_irq    = 1'b0;
        exp_irq    = 1'b0;
        fail_count = 0;
        fail_mark  = 0;
        tests_run  = 0;

        wait_reset();
        @(negedge HCLK);
        chk_reset = 1'b1;
        @(negedge HCLK);
        chk_reset = 1'b0;
        end_test("reset state");

        for (int i = 0; i < word_writes; i++)
        begin
            addr = $random(seed) & 32'h0000_FFFC;
            data = $random(seed);
            ram_write(addr, 3'd2, data);
            written.push_back(addr);
        end
        foreach (written[i])
            ram_check(written[i]);
        end_test("word writes and reads");

        // offsets 1 and 3 of the halfword pass are the misaligned ones.
        base = $random(seed) & 32'h0000_FFFC;
        ram_write(base, 3'd2, $random(seed));
        for (int size = 0; size < 2; size++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                ram_write(base + 32'(off), 3'(size), $random(seed));
                ram_check(base);
            end
        end
        end_test("byte and halfword writes");

        for (int i = 0; i < 8; i++)
        begin
            addr = $random(seed) & 32'h0000_FFFC;
            data = $random(seed);
            ram_model[addr[15:2]] = data;
            write_then_read(addr, data);
        end
        end_test("write then read back to back");

        ahb_write(tmr_base | 32'(tmr_load), 3'd2, 32'd5);
        ahb_read(tmr_base | 32'(tmr_load), 3'd2, 32'd5);
        ahb_write(tmr_base | 32'(tmr_ctrl), 3'd2, 32'h3);    // count with irq enabled.
        wait_irq();
        chk_irq = 1'b1;
        exp_irq = 1'b1;
        @(negedge HCLK);
        chk_irq = 1'b0;
        ahb_write(tmr_base | 32'(tmr_ctrl), 3'd2, 32'h2);    // stop counting, irq stays enabled.
        ahb_write(tmr_base | 32'(tmr_status), 3'd2, 32'h1);
        repeat (2) @(negedge HCLK);                          // irq is registered behind the flag.
        chk_irq = 1'b1;
        exp_irq = 1'b0;
        @(negedge HCLK);
        chk_irq = 1'b0;
        end_test("timer");

        do_transfer(1'b0, 32'h2000_0000, 3'd2, 32'd0, 32'd0, 1'b1);
        do_transfer(1'b1, 32'h8000_0010, 3'd2, 32'hDEAD_BEEF, 32'd0, 1'b1);
        ram_check(written[0]);
        end_test("unmapped address");

        report_and_finish();
    end

endmodule

// File: list.f
+incdir+sim
design/ahb_pkg.sv
design/block_ram.sv
design/ahb_bram_slave.sv
design/ahb_timer_slave.sv
design/ahb_decoder_mux.sv
design/ahb_subsystem_top.sv
sim/tb_clock_gen.sv
sim/ahb_subsystem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the AHB subsystem testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module ahb_subsystem_tb -o ahb_sim \
    || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/ahb_sim)"
echo "$out"
echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1
